// File: run_sim.sh
#!/bin/sh
# Builds the cache testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --timescale 1ns/1ps --top-module cache_tb \
   -f sources.f -o cache_sim > build.log 2>&1 &&
./obj_dir/cache_sim > sim.log 2>&1 ||
{ echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All tests passed" sim.log || { echo "Simulation ended early"; exit 1; }
echo "Simulation PASSED"
exit 0

// File: sources.f
verilog/cache_pkg.sv
verilog/cache_csr_pkg.sv
verilog/cache_control.sv
verilog/cache_memory.sv
verilog/write_through_buffer.sv
verilog/cache_backend.sv
verilog/cache_top.sv
verification/cache_tb.sv

// File: verification/cache_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write-through cache testbench: memory model, reference model of tags,
// shadow memory and counters, directed and random tests.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_tb
   import cache_pkg::*;
   import cache_csr_pkg::*;
();

   localparam int NLINE_W = 4;  // DUT default.
   localparam int NUM_OPS = 300;
   localparam logic [ADDR_W-1:0] WIN_BASE = 16'h0140;
   // A read miss behind four drains stays under 40 cycles.
   localparam int TIMEOUT_CYCLES = NUM_OPS * 40 + 8000;

   typedef struct packed {
      logic              chk;
      logic              ctrl;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } expect_t;

   logic                      clk;
   logic                      arst;
   cache_req_t                req;
   cache_rsp_t                rsp;
   mem_req_t                  mem_req;
   logic                      mem_ready;
   logic [DATA_W-1:0]         mem_rdata;
   logic                      stall;
   logic [DATA_W-1:0]         mem_arr [2**ADDR_W];
   logic [DATA_W-1:0]         shadow  [2**ADDR_W];
   logic [ADDR_W-NLINE_W-1:0] ref_tag [2**NLINE_W];
   logic [2**NLINE_W-1:0]     ref_valid;
   int                        cnt_rh, cnt_rm, cnt_wh, cnt_wm;
   expect_t                   exp_q [$];
   expect_t                   cur_exp;
   logic [DATA_W-1:0]         last_rdata;
   int                        rsp_count, cycles;
   int                        errors, checks, test_errors, ntests, nfailed;

   cache_top DUT (
      .clk_i(clk), .arst_i(arst), .req_i(req), .rsp_o(rsp),
      .mem_req_o(mem_req), .mem_ready_i(mem_ready), .mem_rdata_i(mem_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: the DUT gave no answer within %0d cycles", TIMEOUT_CYCLES);
         $display("Some tests failed");
         $finish;
      end
   end

   // Word memory model that answers after 1 to 4 cycles or later while stalled.
   always begin : mem_model
      logic [ADDR_W-1:0] m_addr;
      @(negedge clk);
      if (mem_req.valid) begin
         m_addr = mem_req.addr;
         if (mem_req.we) begin
            mem_arr[m_addr] = mem_req.wdata;
         end
         repeat (1 + $urandom % 4) @(posedge clk);
         while (stall) @(posedge clk);
         #2;
         mem_ready = 1'b1;
         mem_rdata = mem_arr[m_addr];
         @(posedge clk);
         #2;
         mem_ready = 1'b0;
      end
   end

   always @(negedge clk) begin
      if (rsp.ready) begin
         if (exp_q.size() == 0) begin
            $display("Unexpected response at %0t with no request pending", $time);
            errors++;
         end else begin
            cur_exp = exp_q.pop_front();
            if (cur_exp.chk) begin
               checks++;
               if (rsp.rdata !== cur_exp.data) begin
                  $display("[ERROR] %0t: %s %h read %h, expected %h", $time,
                           cur_exp.ctrl ? "csr" : "addr", cur_exp.addr, rsp.rdata,
                           cur_exp.data);
                  errors++;
               end
            end
         end
         last_rdata = rsp.rdata;
         rsp_count++;
      end
   end

   function automatic logic is_hit(input logic [ADDR_W-1:0] addr);
      return ref_valid[addr[NLINE_W-1:0]]
             && (ref_tag[addr[NLINE_W-1:0]] == addr[ADDR_W-1:NLINE_W]);
   endfunction

   // Reads always see the latest write, from the line or from memory.
   function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
      return shadow[addr];
   endfunction

   function automatic void model_access(input logic we, input logic [ADDR_W-1:0] addr,
                                        input logic [DATA_W-1:0] data);
      logic hit;
      hit = is_hit(addr);
      if (we) begin
         shadow[addr] = data;  // No allocate on a write miss.
         cnt_wh += int'(hit);
         cnt_wm += int'(!hit);
      end else begin
         cnt_rh += int'(hit);
         cnt_rm += int'(!hit);
         ref_valid[addr[NLINE_W-1:0]] = 1'b1;
         ref_tag[addr[NLINE_W-1:0]]   = addr[ADDR_W-1:NLINE_W];
      end
   endfunction

   task automatic access(input logic ctrl, input logic we, input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] exp,
                         input logic chk);
      int count;
      count = rsp_count;
      exp_q.push_back('{chk: chk, ctrl: ctrl, addr: addr, data: exp});
      @(posedge clk);
      #2;
      req = '{valid: 1'b1, ctrl: ctrl, we: we, addr: addr, wdata: wdata};
      @(posedge clk);
      #2;
      req.valid = 1'b0;
      wait (rsp_count != count);
   endtask

   task automatic cache_read(input logic [ADDR_W-1:0] addr);
      logic [DATA_W-1:0] exp;
      exp = expected_read(addr);
      model_access(1'b0, addr, '0);
      access(1'b0, 1'b0, addr, '0, exp, 1'b1);
   endtask

   task automatic cache_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      model_access(1'b1, addr, data);
      access(1'b0, 1'b1, addr, data, '0, 1'b0);
   endtask

   // Commands and status registers go through here too.
   task automatic csr_read(input logic [CSR_ADDR_W-1:0] offset, input logic [DATA_W-1:0] exp);
      access(1'b1, 1'b0, ADDR_W'(offset), '0, exp, 1'b1);
   endtask

   task automatic check_counters();
      csr_read(CSR_READ_HIT, DATA_W'(cnt_rh));
      csr_read(CSR_READ_MISS, DATA_W'(cnt_rm));
      csr_read(CSR_WRITE_HIT, DATA_W'(cnt_wh));
      csr_read(CSR_WRITE_MISS, DATA_W'(cnt_wm));
      csr_read(CSR_HIT, DATA_W'(cnt_rh + cnt_wh));
      csr_read(CSR_MISS, DATA_W'(cnt_rm + cnt_wm));
   endtask

   task automatic reset_counters();
      csr_read(CSR_RST_CNTRS, '0);
      cnt_rh = 0;
      cnt_rm = 0;
      cnt_wh = 0;
      cnt_wm = 0;
   endtask

   task automatic invalidate_cache();
      csr_read(CSR_INVALIDATE, '0);
      ref_valid = '0;
   endtask

   task automatic wait_drained();
      int tries;
      tries = 0;
      do begin
         access(1'b1, 1'b0, ADDR_W'(CSR_WTB_EMPTY), '0, '0, 1'b0);
         tries++;
      end while (last_rdata != 32'd1 && tries < 50);
      if (last_rdata != 32'd1) begin
         $display("Write buffer still not empty after %0d status reads", tries);
         errors++;
      end
   endtask

   task automatic compare_memory();
      logic [ADDR_W-1:0] a;
      for (int i = 0; i < 64; i++) begin
         a = WIN_BASE + ADDR_W'(i);
         checks++;
         if (mem_arr[a] !== shadow[a]) begin
            $display("[ERROR] %0t: memory word %h holds %h, expected %h", $time, a,
                     mem_arr[a], shadow[a]);
            errors++;
         end
      end
   endtask

   task automatic end_test(input string name);
      int n;
      n = errors - test_errors;
      test_errors = errors;
      ntests++;
      nfailed += int'(n != 0);
      $display("Test %-16s %s, %0d errors", name, (n == 0) ? "ok" : "FAILED", n);
   endtask

   initial begin
      logic [ADDR_W-1:0] addr;
      void'($urandom(23945));
      req = '0;
      arst = 1'b1;
      mem_ready = 1'b0;
      mem_rdata = '0;
      stall = 1'b0;
      ref_valid = '0;
      {cnt_rh, cnt_rm, cnt_wh, cnt_wm} = '0;
      {rsp_count, cycles, errors, checks, test_errors, ntests, nfailed} = '0;
      for (int a = 0; a < 2 ** ADDR_W; a++) begin
         mem_arr[ADDR_W'(a)] = 32'(a) * 32'h9E37_79B1;  // Unique per word.
         shadow[ADDR_W'(a)]  = 32'(a) * 32'h9E37_79B1;
      end
      repeat (5) @(posedge clk);
      #2;
      arst = 1'b0;

      csr_read(CSR_VERSION, CACHE_VERSION);
      csr_read(CSR_WTB_EMPTY, 32'd1);
      csr_read(CSR_WTB_FULL, 32'd0);
      check_counters();
      end_test("reset state");

      for (int i = 0; i < NUM_OPS; i++) begin
         addr = WIN_BASE + ADDR_W'($urandom % 64);  // 64 words over 16 lines.
         if ($urandom % 2 == 1) begin
            cache_write(addr, $urandom);
         end else begin
            cache_read(addr);
         end
      end
      wait_drained();
      compare_memory();
      end_test("random traffic");

      check_counters();
      end_test("counters");

      cache_read(WIN_BASE);
      reset_counters();
      check_counters();
      cache_read(WIN_BASE);
      csr_read(CSR_READ_HIT, 32'd1);
      end_test("counter reset");

      invalidate_cache();
      reset_counters();
      cache_read(WIN_BASE + 16'd5);
      cache_read(WIN_BASE + 16'd5);
      csr_read(CSR_READ_HIT, 32'd1);
      invalidate_cache();
      cache_read(WIN_BASE + 16'd5);
      csr_read(CSR_READ_MISS, 32'd2);
      check_counters();
      end_test("invalidate");

      stall = 1'b1;
      for (int i = 0; i < 4; i++) begin
         cache_write(WIN_BASE + 16'd16 + ADDR_W'(i), $urandom);
      end
      csr_read(CSR_WTB_FULL, 32'd1);
      @(posedge clk);
      #2;
      stall = 1'b0;
      cache_read(WIN_BASE + 16'd19);
      wait_drained();
      compare_memory();
      end_test("back-pressure");

      $display("Tests: %0d, failed: %0d, checks: %0d, errors: %0d", ntests, nfailed,
               checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/cache_backend.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory port arbiter: drains the write buffer first, then serves
// read-miss fills, one word access at a time.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_backend
   import cache_pkg::*;
(
   input  logic              clk_i,
   input  logic              arst_i,
   input  logic              wb_empty_i,
   input  wb_entry_t         wb_data_i,
   output logic              wb_pop_o,
   input  logic              fill_req_i,
   input  logic [ADDR_W-1:0] fill_addr_i,
   output logic              fill_done_o,
   output logic [DATA_W-1:0] fill_data_o,
   output mem_req_t          mem_req_o,
   input  logic              mem_ready_i,
   input  logic [DATA_W-1:0] mem_rdata_i
);

   typedef enum logic [1:0] {
      B_IDLE,
      B_WRITE,
      B_READ
   } state_t;

   state_t            state_q;
   logic              start_wr;
   logic              start_rd;
   logic              mem_valid_q;
   logic              mem_we_q;
   logic [ADDR_W-1:0] mem_addr_q;
   logic [DATA_W-1:0] mem_wdata_q;

   assign start_wr = (state_q == B_IDLE) && !wb_empty_i;
   assign start_rd = (state_q == B_IDLE) && wb_empty_i && fill_req_i;  // Drains go first.

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q     <= B_IDLE;
         mem_valid_q <= 1'b0;
      end else begin
         mem_valid_q <= start_wr || start_rd;  // One-cycle strobe.
         if (start_wr) begin
            state_q <= B_WRITE;
         end else if (start_rd) begin
            state_q <= B_READ;
         end else if (mem_ready_i) begin
            state_q <= B_IDLE;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_wr) begin
         mem_we_q    <= 1'b1;
         mem_addr_q  <= wb_data_i.addr;
         mem_wdata_q <= wb_data_i.data;
      end else if (start_rd) begin
         mem_we_q   <= 1'b0;
         mem_addr_q <= fill_addr_i;
      end
   end

   assign mem_req_o   = '{valid: mem_valid_q, we: mem_we_q, addr: mem_addr_q,
                          wdata: mem_wdata_q};
   assign wb_pop_o    = (state_q == B_WRITE) && mem_ready_i;  // Retire on acknowledge.
   assign fill_done_o = (state_q == B_READ) && mem_ready_i;
   assign fill_data_o = mem_rdata_i;

   // Memory answers only an access that is in flight.
   a_ready_in_flight: assert property (@(posedge clk_i) disable iff (arst_i)
      mem_ready_i |-> (state_q != B_IDLE));

endmodule

`default_nettype wire

// File: verilog/cache_control.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache control block: hit and miss statistics, counter reset,
// invalidate command, write-buffer status and version readout.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_control
   import cache_pkg::*;
   import cache_csr_pkg::*;
#(
   parameter int USE_CTRL_CNT = 1
) (
   input  logic         clk_i,
   input  logic         arst_i,
   input  cache_req_t   req_i,
   output cache_rsp_t   rsp_o,
   input  cache_event_t event_i,
   input  logic         wtb_empty_i,
   input  logic         wtb_full_i,
   output logic         invalidate_o
);

   logic [CSR_ADDR_W-1:0] offset;
   logic                  in_csr;
   logic                  rst_cntrs;
   logic [DATA_W-1:0]     read_hit_cnt;
   logic [DATA_W-1:0]     read_miss_cnt;
   logic [DATA_W-1:0]     write_hit_cnt;
   logic [DATA_W-1:0]     write_miss_cnt;
   logic [DATA_W-1:0]     hit_cnt;
   logic [DATA_W-1:0]     miss_cnt;
   logic [DATA_W-1:0]     rdata_next;
   logic [DATA_W-1:0]     rdata_q;
   logic                  ready_q;
   logic                  invalidate_q;

   assign offset    = req_i.addr[CSR_ADDR_W-1:0];
   assign in_csr    = (req_i.addr[ADDR_W-1:CSR_ADDR_W] == '0);  // No aliasing above.
   assign rst_cntrs = req_i.valid && in_csr && (offset == CSR_RST_CNTRS);

   generate
      if (USE_CTRL_CNT != 0) begin : g_cnt
         // Wrapping counters; the array reports one event per access.
         always_ff @(posedge clk_i or posedge arst_i) begin
            if (arst_i) begin
               read_hit_cnt   <= '0;
               read_miss_cnt  <= '0;
               write_hit_cnt  <= '0;
               write_miss_cnt <= '0;
            end else if (rst_cntrs) begin
               read_hit_cnt   <= '0;
               read_miss_cnt  <= '0;
               write_hit_cnt  <= '0;
               write_miss_cnt <= '0;
            end else begin
               read_hit_cnt   <= read_hit_cnt + DATA_W'(event_i.read_hit);
               read_miss_cnt  <= read_miss_cnt + DATA_W'(event_i.read_miss);
               write_hit_cnt  <= write_hit_cnt + DATA_W'(event_i.write_hit);
               write_miss_cnt <= write_miss_cnt + DATA_W'(event_i.write_miss);
            end
         end
      end else begin : g_no_cnt
         assign read_hit_cnt   = '0;  // Counters read zero.
         assign read_miss_cnt  = '0;
         assign write_hit_cnt  = '0;
         assign write_miss_cnt = '0;
      end
   endgenerate

   assign hit_cnt  = read_hit_cnt + write_hit_cnt;
   assign miss_cnt = read_miss_cnt + write_miss_cnt;

   always_comb begin
      rdata_next = '0;
      if (in_csr) begin
         case (offset)
            CSR_HIT:        rdata_next = hit_cnt;
            CSR_MISS:       rdata_next = miss_cnt;
            CSR_READ_HIT:   rdata_next = read_hit_cnt;
            CSR_READ_MISS:  rdata_next = read_miss_cnt;
            CSR_WRITE_HIT:  rdata_next = write_hit_cnt;
            CSR_WRITE_MISS: rdata_next = write_miss_cnt;
            CSR_WTB_EMPTY:  rdata_next = DATA_W'(wtb_empty_i);
            CSR_WTB_FULL:   rdata_next = DATA_W'(wtb_full_i);
            CSR_VERSION:    rdata_next = CACHE_VERSION;
            default:        rdata_next = '0;  // Commands and holes.
         endcase
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         ready_q      <= 1'b0;
         invalidate_q <= 1'b0;
      end else begin
         ready_q      <= req_i.valid;  // Answer one cycle later.
         invalidate_q <= req_i.valid && in_csr && (offset == CSR_INVALIDATE);
      end
   end

   // Zero while idle so the top can OR both answers.
   always_ff @(posedge clk_i) begin
      rdata_q <= req_i.valid ? rdata_next : '0;
   end

   assign rsp_o.ready  = ready_q;
   assign rsp_o.rdata  = rdata_q;
   assign invalidate_o = invalidate_q;

   a_event_onehot: assert property (@(posedge clk_i) disable iff (arst_i)
      $onehot0(event_i));

endmodule

`default_nettype wire

// File: verilog/cache_csr_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache control space: register word offsets and the version word.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cache_csr_pkg;

   localparam int CSR_ADDR_W = 4;  // Offset bits decoded.

   // Read-only counters.
   localparam logic [CSR_ADDR_W-1:0] CSR_HIT        = 4'd0;
   localparam logic [CSR_ADDR_W-1:0] CSR_MISS       = 4'd1;
   localparam logic [CSR_ADDR_W-1:0] CSR_READ_HIT   = 4'd2;
   localparam logic [CSR_ADDR_W-1:0] CSR_READ_MISS  = 4'd3;
   localparam logic [CSR_ADDR_W-1:0] CSR_WRITE_HIT  = 4'd4;
   localparam logic [CSR_ADDR_W-1:0] CSR_WRITE_MISS = 4'd5;
   // Commands that any access triggers.
   localparam logic [CSR_ADDR_W-1:0] CSR_RST_CNTRS  = 4'd6;
   localparam logic [CSR_ADDR_W-1:0] CSR_INVALIDATE = 4'd7;
   // Status.
   localparam logic [CSR_ADDR_W-1:0] CSR_WTB_EMPTY  = 4'd8;
   localparam logic [CSR_ADDR_W-1:0] CSR_WTB_FULL   = 4'd9;
   localparam logic [CSR_ADDR_W-1:0] CSR_VERSION    = 4'd10;

   localparam logic [31:0] CACHE_VERSION = 32'h0001_0200;

endpackage

`default_nettype wire

// File: verilog/cache_memory.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped cache array with one-word lines. Looks up each access,
// pushes writes to the write buffer and fills lines on read misses.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_memory
   import cache_pkg::*;
#(
   parameter int NLINE_W = 4
) (
   input  logic              clk_i,
   input  logic              arst_i,
   input  cache_req_t        req_i,
   output cache_rsp_t        rsp_o,
   input  logic              invalidate_i,
   output cache_event_t      event_o,
   output logic              push_o,
   output wb_entry_t         push_data_o,
   input  logic              wtb_full_i,
   output logic              fill_req_o,
   output logic [ADDR_W-1:0] fill_addr_o,
   input  logic              fill_done_i,
   input  logic [DATA_W-1:0] fill_data_i
);

   localparam int NLINES = 2 ** NLINE_W;
   localparam int TAG_W  = ADDR_W - NLINE_W;

   typedef enum logic [1:0] {
      S_IDLE,
      S_WBUF,  // Write held until the buffer has space.
      S_FILL   // Read miss waiting for memory.
   } state_t;

   state_t            state_q;
   cache_req_t        req_q;
   cache_req_t        cur;
   logic [TAG_W-1:0]  tag_mem  [NLINES];
   logic [DATA_W-1:0] data_mem [NLINES];
   logic [NLINES-1:0] valid_q;
   logic [NLINE_W-1:0] idx;
   logic [TAG_W-1:0]  tag;
   logic              hit;
   logic              wr_go;
   logic              rd_go;
   logic              fill_go;
   logic              ready_q;
   logic [DATA_W-1:0] rdata_q;
   cache_event_t      event_q;

   // New requests look up directly, held ones from the latched copy.
   assign cur = (state_q == S_IDLE) ? req_i : req_q;
   assign idx = cur.addr[NLINE_W-1:0];
   assign tag = cur.addr[ADDR_W-1:NLINE_W];
   assign hit = valid_q[idx] && (tag_mem[idx] == tag);

   assign wr_go   = cur.we && !wtb_full_i
                    && ((state_q == S_IDLE && req_i.valid) || state_q == S_WBUF);
   assign rd_go   = (state_q == S_IDLE) && req_i.valid && !req_i.we && hit;
   assign fill_go = (state_q == S_FILL) && fill_done_i;

   assign push_o      = wr_go;
   assign push_data_o = '{addr: cur.addr, data: cur.wdata};
   assign fill_req_o  = (state_q == S_FILL);
   assign fill_addr_o = req_q.addr;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q <= S_IDLE;
         ready_q <= 1'b0;
         event_q <= '0;
         valid_q <= '0;
      end else begin
         ready_q <= wr_go || rd_go || fill_go;
         event_q <= '{read_hit:   rd_go,
                      read_miss:  fill_go,
                      write_hit:  wr_go && hit,
                      write_miss: wr_go && !hit};
         case (state_q)
            S_IDLE: begin
               if (req_i.valid && !wr_go && !rd_go) begin
                  state_q <= req_i.we ? S_WBUF : S_FILL;
               end
            end
            S_WBUF: begin
               if (wr_go) begin
                  state_q <= S_IDLE;
               end
            end
            S_FILL: begin
               if (fill_done_i) begin
                  state_q <= S_IDLE;
               end
            end
            default: state_q <= S_IDLE;
         endcase
         if (invalidate_i) begin
            valid_q <= '0;  // Whole cache at once.
         end else if (fill_go) begin
            valid_q[idx] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      rdata_q <= '0;
      if (state_q == S_IDLE && req_i.valid) begin
         req_q <= req_i;
      end
      if (rd_go) begin
         rdata_q <= data_mem[idx];
      end
      if (fill_go) begin
         data_mem[idx] <= fill_data_i;
         tag_mem[idx]  <= tag;
         rdata_q       <= fill_data_i;  // Forward the fetched word.
      end
      if (wr_go && hit) begin
         data_mem[idx] <= cur.wdata;  // No allocate on a write miss.
      end
   end

   assign rsp_o.ready = ready_q;
   assign rsp_o.rdata = rdata_q;
   assign event_o     = event_q;

   // Requester keeps a single access outstanding.
   a_no_valid_busy: assert property (@(posedge clk_i) disable iff (arst_i)
      (state_q != S_IDLE) |-> !req_i.valid);

   a_fill_only_on_req: assert property (@(posedge clk_i) disable iff (arst_i)
      fill_done_i |-> (state_q == S_FILL));

endmodule

`default_nettype wire

// File: verilog/cache_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache types: word widths and the request, response, memory,
// write-buffer and event structs shared by all cache blocks.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cache_pkg;

   localparam int ADDR_W = 16;  // Word address.
   localparam int DATA_W = 32;

   typedef struct packed {
      logic              valid;  // One-cycle strobe.
      logic              ctrl;   // Control space access.
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } cache_req_t;

   typedef struct packed {
      logic              ready;  // One-cycle answer.
      logic [DATA_W-1:0] rdata;
   } cache_rsp_t;

   typedef struct packed {
      logic              valid;
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } mem_req_t;

   // Pending memory write.
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } wb_entry_t;

   // One-hot access outcome.
   typedef struct packed {
      logic read_hit;
      logic read_miss;
      logic write_hit;
      logic write_miss;
   } cache_event_t;

endpackage

`default_nettype wire

// File: verilog/cache_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write-through cache top: routes requests to the control block or
// the cache array and connects the write buffer and memory backend.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_top
   import cache_pkg::*;
#(
   parameter int NLINE_W       = 4,
   parameter int WTBUF_DEPTH_W = 2,
   parameter int USE_CTRL_CNT  = 1
) (
   input  logic              clk_i,
   input  logic              arst_i,
   input  cache_req_t        req_i,
   output cache_rsp_t        rsp_o,
   output mem_req_t          mem_req_o,
   input  logic              mem_ready_i,
   input  logic [DATA_W-1:0] mem_rdata_i
);

   cache_req_t        ctrl_req;
   cache_req_t        arr_req;
   cache_rsp_t        ctrl_rsp;
   cache_rsp_t        arr_rsp;
   cache_event_t      cache_event;
   logic              invalidate;
   logic              wtb_push;
   wb_entry_t         wtb_push_data;
   logic              wtb_pop;
   wb_entry_t         wtb_head;
   logic              wtb_empty;
   logic              wtb_full;
   logic              fill_req;
   logic [ADDR_W-1:0] fill_addr;
   logic              fill_done;
   logic [DATA_W-1:0] fill_data;

   always_comb begin
      ctrl_req       = req_i;
      ctrl_req.valid = req_i.valid && req_i.ctrl;
      arr_req        = req_i;
      arr_req.valid  = req_i.valid && !req_i.ctrl;
   end

   // Only one block answers at a time, idle rdata is zero.
   assign rsp_o.ready = ctrl_rsp.ready | arr_rsp.ready;
   assign rsp_o.rdata = ctrl_rsp.rdata | arr_rsp.rdata;

   cache_control #(.USE_CTRL_CNT(USE_CTRL_CNT)) u_control (
      .clk_i, .arst_i, .req_i(ctrl_req), .rsp_o(ctrl_rsp), .event_i(cache_event),
      .wtb_empty_i(wtb_empty), .wtb_full_i(wtb_full), .invalidate_o(invalidate)
   );

   cache_memory #(.NLINE_W(NLINE_W)) u_memory (
      .clk_i, .arst_i, .req_i(arr_req), .rsp_o(arr_rsp), .invalidate_i(invalidate),
      .event_o(cache_event), .push_o(wtb_push), .push_data_o(wtb_push_data),
      .wtb_full_i(wtb_full), .fill_req_o(fill_req), .fill_addr_o(fill_addr),
      .fill_done_i(fill_done), .fill_data_i(fill_data)
   );

   write_through_buffer #(.WTBUF_DEPTH_W(WTBUF_DEPTH_W)) u_wtbuf (
      .clk_i, .arst_i, .push_i(wtb_push), .data_i(wtb_push_data), .pop_i(wtb_pop),
      .data_o(wtb_head), .empty_o(wtb_empty), .full_o(wtb_full)
   );

   cache_backend u_backend (
      .clk_i, .arst_i, .wb_empty_i(wtb_empty), .wb_data_i(wtb_head), .wb_pop_o(wtb_pop),
      .fill_req_i(fill_req), .fill_addr_i(fill_addr), .fill_done_o(fill_done),
      .fill_data_o(fill_data), .mem_req_o, .mem_ready_i, .mem_rdata_i
   );

endmodule

`default_nettype wire

// File: verilog/write_through_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write buffer: circular FIFO of pending memory writes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module write_through_buffer
   import cache_pkg::*;
#(
   parameter int WTBUF_DEPTH_W = 2
) (
   input  logic      clk_i,
   input  logic      arst_i,
   input  logic      push_i,
   input  wb_entry_t data_i,
   input  logic      pop_i,
   output wb_entry_t data_o,
   output logic      empty_o,
   output logic      full_o
);

   localparam int DEPTH = 2 ** WTBUF_DEPTH_W;

   wb_entry_t              entries [DEPTH];
   // Extra top bit tells full from empty.
   logic [WTBUF_DEPTH_W:0] wr_ptr_q;
   logic [WTBUF_DEPTH_W:0] rd_ptr_q;

   assign empty_o = (wr_ptr_q == rd_ptr_q);
   assign full_o  = (wr_ptr_q[WTBUF_DEPTH_W] != rd_ptr_q[WTBUF_DEPTH_W])
                    && (wr_ptr_q[WTBUF_DEPTH_W-1:0] == rd_ptr_q[WTBUF_DEPTH_W-1:0]);
   assign data_o  = entries[rd_ptr_q[WTBUF_DEPTH_W-1:0]];  // Head is always visible.

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         entries[wr_ptr_q[WTBUF_DEPTH_W-1:0]] <= data_i;
      end
   end

   // Producer waits on full, backend drains only real entries.
   a_no_push_full: assert property (@(posedge clk_i) disable iff (arst_i)
      push_i |-> !full_o);

   a_no_pop_empty: assert property (@(posedge clk_i) disable iff (arst_i)
      pop_i |-> !empty_o);

endmodule

`default_nettype wire
